//--- source/shared_mem_pkg.sv
package shared_mem_pkg;

    localparam int NUM_REQ     = 3;
    localparam int QUEUE_DEPTH = 2;    // power of two
    localparam int ADDR_W      = 8;
    localparam int DATA_W      = 32;
    localparam int SRC_W       = $clog2(NUM_REQ);
    localparam int BANK_WORDS  = 2 ** ADDR_W;

    typedef logic [ADDR_W-1:0]  word_addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [SRC_W-1:0]   src_id_t;
    typedef logic [NUM_REQ-1:0] req_vec_t;    // one bit per requester

    typedef struct packed {
        logic       write;
        word_addr_t addr;
        data_t      wdata;
    } mem_req_t;

    typedef struct packed {
        mem_req_t req;
        logic     critical;
    } queue_entry_t;

    typedef struct packed {
        mem_req_t req;
        src_id_t  src;
    } mem_cmd_t;

    typedef struct packed {
        src_id_t src;
        logic    write;
        data_t   rdata;    // don't care on writes
    } mem_rsp_t;

    typedef enum logic [1:0] {BANK_IDLE, BANK_ACCESS, BANK_RESPOND} bank_state_t;

endpackage

//--- source/fifo_queue.sv
module fifo_queue
(
    input  logic                         clk_in,
    input  logic                         reset_in,

    input  shared_mem_pkg::queue_entry_t push_entry,
    input  logic                         push_valid,
    output logic                         push_ack,

    input  logic                         pop,
    output shared_mem_pkg::queue_entry_t head,
    output logic                         head_valid,
    output logic                         is_full
);
    import shared_mem_pkg::*;

    queue_entry_t                     entries [QUEUE_DEPTH];
    logic [$clog2(QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(QUEUE_DEPTH+1)-1:0] count;

    assign is_full    = (count == QUEUE_DEPTH);
    assign head_valid = (count != '0);
    assign push_ack   = push_valid && !is_full && !reset_in;    // same-cycle acknowledge
    assign head       = entries[rd_ptr];

    always_ff @(posedge clk_in)
    begin
        if (push_ack)
            entries[wr_ptr] <= push_entry;
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ack)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;

            case ({push_ack, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    // the arbiter must only pop a head it has actually seen
    pop_not_empty: assert property (
        @(posedge clk_in) disable iff (reset_in)
        pop |-> head_valid
    ) else $error("fifo_queue: pop while empty");

endmodule

//--- source/priority_arbiter.sv
module priority_arbiter
(
    input  logic                     clk_in,
    input  logic                     reset_in,

    input  shared_mem_pkg::mem_req_t req [shared_mem_pkg::NUM_REQ],
    input  shared_mem_pkg::req_vec_t req_valid,
    input  shared_mem_pkg::req_vec_t req_critical,
    output shared_mem_pkg::req_vec_t req_ack,

    output shared_mem_pkg::mem_cmd_t cmd,
    output logic                     cmd_valid,
    input  logic                     cmd_ack
);
    import shared_mem_pkg::*;

    queue_entry_t push_entry [NUM_REQ];
    queue_entry_t head [NUM_REQ];
    req_vec_t     head_valid;
    req_vec_t     head_crit;
    req_vec_t     queue_full;
    req_vec_t     pop;           // registered, one cycle after the load

    req_vec_t     eligible;
    req_vec_t     crit_mask;
    src_id_t      last_winner;
    src_id_t      crit_sel;
    src_id_t      valid_sel;
    src_id_t      winner;
    logic         grant_any;
    logic         load_ok;

    for (genvar i = 0; i < NUM_REQ; i++)
    begin : g_queue
        assign push_entry[i] = '{req: req[i], critical: req_critical[i]};
        assign head_crit[i]  = head[i].critical;

        fifo_queue queue
        (
            .clk_in     (clk_in),
            .reset_in   (reset_in),
            .push_entry (push_entry[i]),
            .push_valid (req_valid[i]),
            .push_ack   (req_ack[i]),
            .pop        (pop[i]),
            .head       (head[i]),
            .head_valid (head_valid[i]),
            .is_full    (queue_full[i])
        );
    end

    // nearest set bit after start, going round; start itself is checked last
    function automatic src_id_t rotate_first(input req_vec_t mask, input src_id_t start);
        src_id_t     sel;
        int unsigned idx;
        sel = start;
        for (int k = NUM_REQ; k >= 1; k--)
        begin
            idx = (int'(start) + k) % NUM_REQ;
            if (mask[idx])
                sel = src_id_t'(idx);
        end
        return sel;
    endfunction

    // a head whose pop is still in flight was already issued
    assign eligible  = head_valid & ~pop;
    assign crit_mask = (head_crit | queue_full) & eligible;    // full queue counts as critical

    assign crit_sel  = rotate_first(crit_mask, last_winner);
    assign valid_sel = rotate_first(eligible, last_winner);
    assign winner    = (|crit_mask) ? crit_sel : valid_sel;
    assign grant_any = |eligible;
    assign load_ok   = !cmd_valid || cmd_ack;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            cmd_valid   <= 1'b0;
            pop         <= '0;
            last_winner <= '0;
        end
        else
        begin
            pop <= '0;
            if (load_ok)
            begin
                cmd_valid <= grant_any;
                if (grant_any)
                begin
                    pop[winner] <= 1'b1;
                    last_winner <= winner;
                end
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (load_ok && grant_any)
        begin
            cmd.req <= head[winner].req;
            cmd.src <= winner;
        end
    end

    // a queue with its pop pending is never picked again
    pop_no_repeat: assert property (
        @(posedge clk_in) disable iff (reset_in)
        (pop & $past(pop)) == '0
    ) else $error("priority_arbiter: same queue popped twice in a row");

    // bank back-pressure holds the command in place
    cmd_hold: assert property (
        @(posedge clk_in) disable iff (reset_in)
        cmd_valid && !cmd_ack |=> cmd_valid && $stable(cmd)
    ) else $error("priority_arbiter: cmd changed before ack");

endmodule

//--- source/memory_bank.sv
module memory_bank
(
    input  logic                     clk_in,
    input  logic                     reset_in,

    input  shared_mem_pkg::mem_cmd_t cmd,
    input  logic                     cmd_valid,
    output logic                     cmd_ack,

    output shared_mem_pkg::mem_rsp_t rsp,
    output logic                     rsp_valid
);
    import shared_mem_pkg::*;

    bank_state_t state;
    mem_cmd_t    cmd_q;    // command captured at accept
    data_t       mem [BANK_WORDS];

    assign cmd_ack = cmd_valid && (state == BANK_IDLE);

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state     <= BANK_IDLE;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= (state == BANK_RESPOND);
            case (state)
                BANK_IDLE:    if (cmd_ack) state <= BANK_ACCESS;
                BANK_ACCESS:  state <= BANK_RESPOND;
                BANK_RESPOND: state <= BANK_IDLE;
                default:      state <= BANK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (cmd_ack)
            cmd_q <= cmd;
    end

    // contents come up as zero
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            for (int w = 0; w < BANK_WORDS; w++)
                mem[w] <= '0;
        end
        else if (state == BANK_ACCESS && cmd_q.req.write)
            mem[cmd_q.req.addr] <= cmd_q.req.wdata;
    end

    always_ff @(posedge clk_in)
    begin
        if (state == BANK_RESPOND)
        begin
            rsp.src   <= cmd_q.src;
            rsp.write <= cmd_q.req.write;
            rsp.rdata <= cmd_q.req.write ? '0 : mem[cmd_q.req.addr];
        end
    end

    rsp_spacing: assert property (
        @(posedge clk_in) disable iff (reset_in)
        rsp_valid |=> !rsp_valid
    ) else $error("memory_bank: back-to-back responses");

endmodule

//--- source/shared_mem_top.sv
module shared_mem_top
(
    input  logic                     clk_in,
    input  logic                     reset_in,

    input  shared_mem_pkg::mem_req_t req [shared_mem_pkg::NUM_REQ],
    input  shared_mem_pkg::req_vec_t req_valid,
    input  shared_mem_pkg::req_vec_t req_critical,
    output shared_mem_pkg::req_vec_t req_ack,

    output shared_mem_pkg::mem_rsp_t rsp,
    output logic                     rsp_valid
);
    import shared_mem_pkg::*;

    mem_cmd_t cmd;
    logic     cmd_valid;
    logic     cmd_ack;

    priority_arbiter arb0
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .req          (req),
        .req_valid    (req_valid),
        .req_critical (req_critical),
        .req_ack      (req_ack),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ack      (cmd_ack)
    );

    memory_bank bank0
    (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ack   (cmd_ack),
        .rsp       (rsp),
        .rsp_valid (rsp_valid)
    );

endmodule

//--- include/shared_mem_model.svh
`ifndef SHARED_MEM_MODEL_SVH
`define SHARED_MEM_MODEL_SVH

typedef struct packed {
    shared_mem_pkg::mem_req_t req;
    int                       rsp_stamp;    // global response count at accept
    int                       own_stamp;    // own response count at accept
} exp_t;

shared_mem_pkg::data_t model_mem [shared_mem_pkg::BANK_WORDS];
exp_t                  expected [shared_mem_pkg::NUM_REQ][$];
int                    served [shared_mem_pkg::NUM_REQ];
int                    rsp_count;
int                    last_src;
int                    last_gap;    // other-source responses seen by the last one

function automatic void clear_model();
    foreach (model_mem[i])
        model_mem[i] = '0;
    foreach (served[i])
        served[i] = 0;
    rsp_count = 0;
    last_src  = shared_mem_pkg::NUM_REQ - 1;
    last_gap  = 0;
endfunction

function automatic void record_accept(int src, shared_mem_pkg::mem_req_t req);
    exp_t e;
    e.req       = req;
    e.rsp_stamp = rsp_count;
    e.own_stamp = served[src];
    expected[src].push_back(e);
endfunction

function automatic int outstanding(int src);
    return expected[src].size();
endfunction

// 0 when the response has no match or carries wrong data
function automatic bit match_response(shared_mem_pkg::mem_rsp_t rsp);
    exp_t e;
    bit   ok;
    if (expected[rsp.src].size() == 0)
        return 0;
    e        = expected[rsp.src].pop_front();
    ok       = (e.req.write == rsp.write);
    last_gap = (rsp_count - e.rsp_stamp) - (served[rsp.src] - e.own_stamp);
    if (e.req.write)
        model_mem[e.req.addr] = e.req.wdata;
    else if (model_mem[e.req.addr] != rsp.rdata)
        ok = 0;
    served[rsp.src]++;
    rsp_count++;
    return ok;
endfunction

// round robin order check, also advances the tracked source
function automatic bit in_sequence(int src);
    bit ok;
    ok       = (src == (last_src + 1) % shared_mem_pkg::NUM_REQ);
    last_src = src;
    return ok;
endfunction

`endif

//--- bench/shared_mem_tb.sv
module shared_mem_tb;
    import shared_mem_pkg::*;

    `include "shared_mem_model.svh"

    localparam int unsigned SEED    = 32'hef5e_e06f;
    localparam int RANDOM_REQS      = 240;
    localparam int ROUND_ROBIN_REQS = 120;
    localparam int FLOOD_REQS       = 120;
    localparam int TOTAL_REQS       = RANDOM_REQS + ROUND_ROBIN_REQS + FLOOD_REQS;
    localparam int RR_WARMUP        = 4;    // responses before the rotation settles
    localparam int DRAIN_LIMIT      = 100;  // cycles for all queues and the bank to empty

    logic     clk_in;
    logic     reset_in;
    mem_req_t req [NUM_REQ];
    req_vec_t req_valid;
    req_vec_t req_critical;
    req_vec_t req_ack;
    mem_rsp_t rsp;
    logic     rsp_valid;

    int       phase;           // 0 idle, 1 random, 2 all continuous, 3 critical flood
    bit       reset_window;
    req_vec_t acked;           // req_ack as seen before the last rising edge
    int       accepted;
    int       rr_seen;
    int       data_errs  = 0;
    int       order_errs = 0;
    int       rr_errs    = 0;
    int       crit_errs  = 0;
    int       ack_errs   = 0;
    int       reset_errs = 0;

    shared_mem_top dut0
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .req          (req),
        .req_valid    (req_valid),
        .req_critical (req_critical),
        .req_ack      (req_ack),
        .rsp          (rsp),
        .rsp_valid    (rsp_valid)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    function automatic bit wants_request(int i);
        case (phase)
            1:       return ($urandom % 2) == 0;
            2:       return 1'b1;
            3:       return (i < 2) || (outstanding(2) == 0 && ($urandom % 4) == 0);
            default: return 1'b0;
        endcase
    endfunction

    function automatic bit drained();
        for (int i = 0; i < NUM_REQ; i++)
            if (outstanding(i) != 0)
                return 1'b0;
        return 1'b1;
    endfunction

    function automatic int error_total();
        return data_errs + order_errs + rr_errs + crit_errs + ack_errs + reset_errs;
    endfunction

    task automatic print_counts();
        $display("error counts: data %0d order %0d rr %0d critical %0d ack %0d reset %0d",
                 data_errs, order_errs, rr_errs, crit_errs, ack_errs, reset_errs);
    endtask

    task automatic check_response();
        int src;
        bit ok;
        src = int'(rsp.src);
        ok  = (src < NUM_REQ) && (outstanding(src) > 0);
        assert (ok)
        else
        begin
            order_errs++;
            $display("ERR @%0t: response for source %0d with nothing outstanding", $time, src);
        end
        if (ok)
        begin
            ok = match_response(rsp);
            assert (ok)
            else
            begin
                data_errs++;
                $display("ERR @%0t: source %0d write %0b rdata %h does not match the model",
                         $time, src, rsp.write, rsp.rdata);
            end
            if (phase == 3 && src == 2)
            begin
                assert (last_gap <= QUEUE_DEPTH + 1)
                else
                begin
                    crit_errs++;
                    $display("ERR @%0t: critical request waited behind %0d responses",
                             $time, last_gap);
                end
            end
            if (phase == 2)
            begin
                ok = in_sequence(src);
                rr_seen++;
                assert (ok || rr_seen <= RR_WARMUP)
                else
                begin
                    rr_errs++;
                    $display("ERR @%0t: source %0d out of round robin order", $time, src);
                end
            end
        end
    endtask

    task automatic check_drained();
        for (int i = 0; i < NUM_REQ; i++)
        begin
            assert (outstanding(i) == 0)
            else
            begin
                order_errs++;
                $display("ERR @%0t: source %0d still waits for %0d responses",
                         $time, i, outstanding(i));
            end
        end
    endtask

    // new request once the previous one was taken, held otherwise
    initial
    begin
        void'($urandom(SEED));
        @(negedge reset_in);
        forever
        begin
            @(posedge clk_in);
            #1;
            for (int i = 0; i < NUM_REQ; i++)
            begin
                if (!req_valid[i] || acked[i])
                begin
                    req_valid[i]    = wants_request(i);
                    req_critical[i] = (phase == 3 && i == 2) || (phase == 1 && ($urandom % 4) == 0);
                    req[i].write    = 1'($urandom_range(1, 0));
                    req[i].addr     = word_addr_t'($urandom % 16);    // small window, reads hit writes
                    req[i].wdata    = data_t'($urandom);
                end
            end
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk_in)
    begin
        if (reset_window)
        begin
            assert (!rsp_valid && req_ack == '0)
            else
            begin
                reset_errs++;
                $display("ERR @%0t: rsp_valid or req_ack high around reset", $time);
            end
        end
        if (!reset_in)
        begin
            if (rsp_valid)
                check_response();    // before accepts, the bank slot is free again
            for (int i = 0; i < NUM_REQ; i++)
            begin
                assert (!(req_ack[i] && outstanding(i) >= QUEUE_DEPTH + 2))
                else
                begin
                    ack_errs++;
                    $display("ERR @%0t: source %0d acked with %0d outstanding",
                             $time, i, outstanding(i));
                end
                if (req_ack[i])
                begin
                    record_accept(i, req[i]);
                    accepted++;
                end
            end
        end
        acked = req_ack;
    end

    task automatic run_phase(int which, int reqs);
        int target;
        int waited;
        target  = accepted + reqs;
        rr_seen = 0;
        phase   = which;
        while (accepted < target)
            @(posedge clk_in);
        phase  = 0;
        waited = 0;
        while ((req_valid != '0 || !drained()) && waited < DRAIN_LIMIT)
        begin
            @(posedge clk_in);
            waited++;
        end
        check_drained();
    endtask

    initial
    begin
        clear_model();
        reset_in     = 1'b1;
        req_valid    = '1;    // requests wait through reset without an ack
        req_critical = '0;
        foreach (req[i])
            req[i] = '0;
        phase        = 0;
        reset_window = 1'b1;
        acked        = '0;
        accepted     = 0;
        rr_seen      = 0;
        repeat (5) @(posedge clk_in);
        #1;
        reset_in  = 1'b0;
        req_valid = '0;
        @(posedge clk_in);
        reset_window = 1'b0;

        run_phase(1, RANDOM_REQS);
        run_phase(2, ROUND_ROBIN_REQS);
        run_phase(3, FLOOD_REQS);
        repeat (20) @(posedge clk_in);    // catch stray responses

        print_counts();
        if (error_total() == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin
        repeat (TOTAL_REQS * 40) @(posedge clk_in);
        $display("watchdog: run did not finish within %0d cycles", TOTAL_REQS * 40);
        print_counts();
        $display("Errors found");
        $finish;
    end

endmodule

//--- shared_mem.f
+incdir+include
source/shared_mem_pkg.sv
source/fifo_queue.sv
source/priority_arbiter.sv
source/memory_bank.sv
source/shared_mem_top.sv
bench/shared_mem_tb.sv

//--- Bender.yml
package:
  name: shared_mem

sources:
  # package first, then the RTL leaves up to the top level
  - files:
      - source/shared_mem_pkg.sv
      - source/fifo_queue.sv
      - source/priority_arbiter.sv
      - source/memory_bank.sv
      - source/shared_mem_top.sv

  # testbench with its reference model header
  - target: test
    include_dirs:
      - include
    files:
      - bench/shared_mem_tb.sv
